//--- design/bench_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "bench_defs.svh"

module bench_top (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 cmd_valid,
    input  cmd_pkg::op_e         cmd_op,
    input  logic [`N_CHAN-1:0]   cmd_mask,
    input  chan_pkg::pat_e       cmd_btype,
    output logic                 cmd_busy,

    input  logic [`N_CHAN-1:0]   pin_rxd,
    input  logic [`N_CHAN-1:0]   pin_read,
    output logic [`N_CHAN-1:0]   pin_txd,
    output logic [`N_CHAN-1:0]   pin_send,

    output logic                 out_valid,
    output logic [7:0]           out_data,
    output logic                 out_last
);

    logic [`N_CHAN-1:0]   fs_send;
    logic [`N_CHAN-1:0]   fd_send;
    logic [`N_CHAN-1:0]   fs_read;
    logic [`N_CHAN-1:0]   fd_read;
    logic [`N_CHAN-1:0]   clr;
    chan_pkg::pat_e       btype;
    logic                 fs_data;
    logic                 fd_data;

    logic [`CAP_AW-1:0]   cap_addr;
    logic [`N_CHAN*8-1:0] cap_data;
    logic [`N_CHAN*8-1:0] err_cnt;
    logic [`N_CHAN*5-1:0] byte_cnt;

    cmd_console console_dut (
        .clk(clk),
        .rst(rst),
        .cmd_valid(cmd_valid),
        .cmd_op(cmd_op),
        .cmd_mask(cmd_mask),
        .cmd_btype(cmd_btype),
        .cmd_busy(cmd_busy),
        .fs_send(fs_send),
        .fd_send(fd_send),
        .fs_read(fs_read),
        .fd_read(fd_read),
        .clr(clr),
        .btype(btype),
        .fs_data(fs_data),
        .fd_data(fd_data)
    );

    genvar i;
    generate
        for (i = 0; i < `N_CHAN; i = i + 1) begin : chan_inst
            serial_chan chan_dut (
                .clk(clk),
                .rst(rst),
                .clr(clr[i]),
                .fs_send(fs_send[i]),
                .fd_send(fd_send[i]),
                .fs_read(fs_read[i]),
                .fd_read(fd_read[i]),
                .btype(btype),
                .pin_rxd(pin_rxd[i]),
                .pin_read(pin_read[i]),
                .pin_txd(pin_txd[i]),
                .pin_send(pin_send[i]),
                .cap_addr(cap_addr),
                .cap_data(cap_data[8*i +: 8]),
                .err_cnt(err_cnt[8*i +: 8]),
                .byte_cnt(byte_cnt[5*i +: 5])
            );
        end
    endgenerate

    frame_builder data_dut (
        .clk(clk),
        .rst(rst),
        .fs_data(fs_data),
        .fd_data(fd_data),
        .cap_addr(cap_addr),
        .cap_data(cap_data),
        .err_cnt(err_cnt),
        .byte_cnt(byte_cnt),
        .out_valid(out_valid),
        .out_data(out_data),
        .out_last(out_last)
    );

endmodule

`default_nettype wire

//--- design/chan_pkg.sv
`default_nettype none

package chan_pkg;

    typedef enum logic [1:0] {
        PAT_ZERO = 2'd0,
        PAT_ONES = 2'd1,
        PAT_INC  = 2'd2,
        PAT_PRBS = 2'd3
    } pat_e;

    typedef enum logic [2:0] {
        CH_IDLE,
        CH_SEND,
        CH_ARMED, // read started, pin_read not yet seen
        CH_READ,
        CH_DONE
    } chan_state_e;

endpackage

`default_nettype wire

//--- design/cmd_console.sv
`timescale 1ns/100ps
`default_nettype none

`include "bench_defs.svh"

module cmd_console (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 cmd_valid,
    input  cmd_pkg::op_e         cmd_op,
    input  logic [`N_CHAN-1:0]   cmd_mask,
    input  chan_pkg::pat_e       cmd_btype,
    output logic                 cmd_busy,

    output logic [`N_CHAN-1:0]   fs_send,
    input  logic [`N_CHAN-1:0]   fd_send,
    output logic [`N_CHAN-1:0]   fs_read,
    input  logic [`N_CHAN-1:0]   fd_read,
    output logic [`N_CHAN-1:0]   clr,
    output chan_pkg::pat_e       btype,

    output logic                 fs_data,
    input  logic                 fd_data
);

    cmd_pkg::con_state_e state;
    logic [`N_CHAN-1:0]  pend;
    logic [`N_CHAN-1:0]  pend_nxt;

    assign cmd_busy = (state != cmd_pkg::CON_IDLE);
    assign pend_nxt = pend & ~(fd_send | fd_read); // drop channels reporting done

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= cmd_pkg::CON_IDLE;
            pend    <= '0;
            fs_send <= '0;
            fs_read <= '0;
            clr     <= '0;
            fs_data <= 1'b0;
            btype   <= chan_pkg::PAT_ZERO;
        end else begin
            fs_send <= '0;
            fs_read <= '0;
            clr     <= '0;
            fs_data <= 1'b0;
            case (state)
                cmd_pkg::CON_IDLE: begin
                    if (cmd_valid) begin
                        case (cmd_op)
                            cmd_pkg::OP_SEND: begin
                                fs_send <= cmd_mask;
                                pend    <= cmd_mask;
                                btype   <= cmd_btype;
                                state   <= cmd_pkg::CON_WAIT_CHAN;
                            end
                            cmd_pkg::OP_READ: begin
                                fs_read <= cmd_mask;
                                pend    <= cmd_mask;
                                btype   <= cmd_btype;
                                state   <= cmd_pkg::CON_WAIT_CHAN;
                            end
                            cmd_pkg::OP_DUMP: begin
                                fs_data <= 1'b1;
                                state   <= cmd_pkg::CON_WAIT_DUMP;
                            end
                            cmd_pkg::OP_CLEAR: clr <= cmd_mask;
                            default: ;
                        endcase
                    end
                end
                cmd_pkg::CON_WAIT_CHAN: begin
                    pend <= pend_nxt;
                    if (pend_nxt == '0)
                        state <= cmd_pkg::CON_IDLE; // empty mask exits here too
                end
                cmd_pkg::CON_WAIT_DUMP: begin
                    if (fd_data)
                        state <= cmd_pkg::CON_IDLE;
                end
                default: state <= cmd_pkg::CON_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/cmd_pkg.sv
`default_nettype none

package cmd_pkg;

    typedef enum logic [2:0] {
        OP_NOP   = 3'd0,
        OP_SEND  = 3'd1,
        OP_READ  = 3'd2,
        OP_DUMP  = 3'd3,
        OP_CLEAR = 3'd4
    } op_e;

    typedef enum logic [1:0] {
        CON_IDLE,
        CON_WAIT_CHAN, // waiting on channel done pulses
        CON_WAIT_DUMP
    } con_state_e;

endpackage

`default_nettype wire

//--- design/frame_builder.sv
`timescale 1ns/100ps
`default_nettype none

`include "bench_defs.svh"

module frame_builder (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   fs_data,
    output logic                   fd_data,

    output logic [`CAP_AW-1:0]     cap_addr,
    input  logic [`N_CHAN*8-1:0]   cap_data,
    input  logic [`N_CHAN*8-1:0]   err_cnt,
    input  logic [`N_CHAN*5-1:0]   byte_cnt,

    output logic                   out_valid,
    output logic [7:0]             out_data,
    output logic                   out_last
);

    logic                          run;
    logic                          hdr;
    logic [$clog2(`N_CHAN)-1:0]    ch;
    logic [4:0]                    b_idx; // 0 err, 1 count, 2.. capture
    logic                          last;

    logic                          s_vld;
    logic                          s_hdr;
    logic                          s_last;
    logic [$clog2(`N_CHAN)-1:0]    s_ch;
    logic [4:0]                    s_b;

    assign last     = run & ~hdr & (ch == `N_CHAN-1) & (b_idx == `CAP_DEPTH+1);
    assign cap_addr = `CAP_AW'(b_idx - 5'd2);

    always_ff @(posedge clk) begin
        if (rst) begin
            run   <= 1'b0;
            hdr   <= 1'b0;
            ch    <= '0;
            b_idx <= 5'd0;
        end else if (!run) begin
            if (fs_data) begin
                run   <= 1'b1;
                hdr   <= 1'b1;
                ch    <= '0;
                b_idx <= 5'd0;
            end
        end else if (hdr) begin
            hdr <= 1'b0;
        end else if (b_idx == `CAP_DEPTH+1) begin
            b_idx <= 5'd0;
            if (ch == `N_CHAN-1)
                run <= 1'b0;
            else
                ch <= ch + 1'b1;
        end else begin
            b_idx <= b_idx + 5'd1;
        end
    end

    // select delayed to line up with the memory read
    always_ff @(posedge clk) begin
        if (rst) begin
            s_vld     <= 1'b0;
            s_last    <= 1'b0;
            out_valid <= 1'b0;
            out_last  <= 1'b0;
            fd_data   <= 1'b0;
        end else begin
            s_vld     <= run;
            s_last    <= last;
            out_valid <= s_vld;
            out_last  <= s_last;
            fd_data   <= out_last;
        end
        s_hdr <= hdr;
        s_ch  <= ch;
        s_b   <= b_idx;
    end

    always_ff @(posedge clk) begin
        if (s_hdr)
            out_data <= `FRAME_HDR;
        else if (s_b == 5'd0)
            out_data <= err_cnt[s_ch*8 +: 8];
        else if (s_b == 5'd1)
            out_data <= {3'b000, byte_cnt[s_ch*5 +: 5]};
        else
            out_data <= cap_data[s_ch*8 +: 8];
    end

endmodule

`default_nettype wire

//--- design/pattern_gen.sv
`timescale 1ns/100ps
`default_nettype none

module pattern_gen (
    input  logic           clk,
    input  logic           rst,
    input  logic           load,
    input  logic           step,
    input  chan_pkg::pat_e btype,
    output logic [7:0]     pat_byte
);

    chan_pkg::pat_e cur_type;
    logic [7:0]     cur;
    logic           fb;

    assign fb = cur[7] ^ cur[5] ^ cur[4] ^ cur[3]; // prbs feedback
    assign pat_byte = cur;

    always_ff @(posedge clk) begin
        if (rst) begin
            cur_type <= chan_pkg::PAT_ZERO;
            cur      <= 8'h00;
        end else if (load) begin
            cur_type <= btype;
            case (btype)
                chan_pkg::PAT_ONES: cur <= 8'hFF;
                chan_pkg::PAT_PRBS: cur <= 8'h01; // prbs seed
                default:            cur <= 8'h00;
            endcase
        end else if (step) begin
            case (cur_type)
                chan_pkg::PAT_ZERO: cur <= 8'h00;
                chan_pkg::PAT_ONES: cur <= 8'hFF;
                chan_pkg::PAT_INC:  cur <= cur + 8'd1;
                chan_pkg::PAT_PRBS: cur <= {cur[6:0], fb};
                default:            cur <= 8'h00;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/serial_chan.sv
`timescale 1ns/100ps
`default_nettype none

`include "bench_defs.svh"

module serial_chan (
    input  logic              clk,
    input  logic              rst,
    input  logic              clr,

    input  logic              fs_send,
    output logic              fd_send,
    input  logic              fs_read,
    output logic              fd_read,
    input  chan_pkg::pat_e    btype,

    input  logic              pin_rxd,
    input  logic              pin_read,
    output logic              pin_txd,
    output logic              pin_send,

    input  logic [`CAP_AW-1:0] cap_addr,
    output logic [7:0]        cap_data,
    output logic [7:0]        err_cnt,
    output logic [4:0]        byte_cnt
);

    chan_pkg::chan_state_e               state;
    logic [$clog2(8*`CAP_DEPTH)-1:0]     bit_cnt;
    logic [7:0]                          rx_sh;
    logic [7:0]                          rx_byte;
    logic [7:0]                          mem [`CAP_DEPTH];
    logic [`CAP_DEPTH-1:0]               mem_ok;
    logic                                pg_load;
    logic                                pg_step;
    logic [7:0]                          pat_byte;
    logic                                rx_take;
    logic                                rx_full;

    assign pin_send = (state == chan_pkg::CH_SEND);
    assign pin_txd  = pin_send & pat_byte[bit_cnt[2:0]]; // lsb first

    assign rx_take = pin_read & ((state == chan_pkg::CH_ARMED) || (state == chan_pkg::CH_READ));
    assign rx_full = rx_take & (bit_cnt[2:0] == 3'd7);
    assign rx_byte = {pin_rxd, rx_sh[7:1]};

    // one generator, tx and rx never overlap
    assign pg_load = (state == chan_pkg::CH_IDLE) & (fs_send | fs_read);
    assign pg_step = (pin_send & (bit_cnt[2:0] == 3'd7)) | rx_full;

    pattern_gen pgen (
        .clk(clk),
        .rst(rst),
        .load(pg_load),
        .step(pg_step),
        .btype(btype),
        .pat_byte(pat_byte)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= chan_pkg::CH_IDLE;
            bit_cnt  <= '0;
            fd_send  <= 1'b0;
            fd_read  <= 1'b0;
            err_cnt  <= 8'h00;
            byte_cnt <= 5'd0;
            mem_ok   <= '0;
        end else begin
            fd_send <= 1'b0;
            fd_read <= 1'b0;
            if (clr) begin
                err_cnt  <= 8'h00;
                byte_cnt <= 5'd0;
                mem_ok   <= '0;
            end
            case (state)
                chan_pkg::CH_IDLE: begin
                    if (fs_send) begin
                        state   <= chan_pkg::CH_SEND;
                        bit_cnt <= '0;
                    end else if (fs_read) begin
                        state    <= chan_pkg::CH_ARMED;
                        bit_cnt  <= '0;
                        err_cnt  <= 8'h00;
                        byte_cnt <= 5'd0;
                        mem_ok   <= '0;
                    end
                end
                chan_pkg::CH_SEND: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == 8*`CAP_DEPTH-1)
                        state <= chan_pkg::CH_DONE;
                end
                chan_pkg::CH_DONE: begin
                    fd_send <= 1'b1; // one cycle after pin_send drops
                    state   <= chan_pkg::CH_IDLE;
                end
                chan_pkg::CH_ARMED, chan_pkg::CH_READ: begin
                    if (rx_take) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        state   <= chan_pkg::CH_READ;
                        if (rx_full) begin
                            mem_ok[byte_cnt[`CAP_AW-1:0]] <= 1'b1;
                            byte_cnt <= byte_cnt + 5'd1;
                            if (rx_byte != pat_byte && err_cnt != 8'hFF)
                                err_cnt <= err_cnt + 8'd1; // saturating
                            if (byte_cnt == `CAP_DEPTH-1) begin
                                fd_read <= 1'b1; // memory full
                                state   <= chan_pkg::CH_IDLE;
                            end
                        end
                    end else if (state == chan_pkg::CH_READ) begin
                        fd_read <= 1'b1; // pin_read fell, partial byte lost
                        state   <= chan_pkg::CH_IDLE;
                    end
                end
                default: state <= chan_pkg::CH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rx_take)
            rx_sh <= rx_byte;
        if (rx_full)
            mem[byte_cnt[`CAP_AW-1:0]] <= rx_byte;
        cap_data <= mem_ok[cap_addr] ? mem[cap_addr] : 8'h00; // unwritten reads 0
    end

endmodule

`default_nettype wire

//--- include/bench_defs.svh
`ifndef BENCH_DEFS_SVH
`define BENCH_DEFS_SVH

// number of test channels
`define N_CHAN 8

// bytes per send and capture memory size
`define CAP_DEPTH 16

// capture memory address width
`define CAP_AW 4

// first byte of a dump frame
`define FRAME_HDR 8'hA5

`endif

//--- run.sh
#!/usr/bin/env bash
# build and run the channel bench testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timing -f sim.f --top-module bench_tb \
    -Mdir obj_dir -o bench_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/bench_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
    exit 0
fi
exit 1

//--- sim.f
+incdir+include
design/cmd_pkg.sv
design/chan_pkg.sv
design/pattern_gen.sv
design/cmd_console.sv
design/serial_chan.sv
design/frame_builder.sv
design/bench_top.sv
verif/bench_checker.sv
verif/bench_tb.sv

//--- verif/bench_checker.sv
`timescale 1ns/100ps
`default_nettype none

`include "bench_defs.svh"

module bench_checker (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cmd_busy,
    input  logic [`N_CHAN-1:0]   pin_send,
    input  logic [`N_CHAN-1:0]   pin_txd,
    input  logic                 out_valid,
    input  logic [7:0]           out_data,
    input  logic                 out_last
);

    last_with_valid: assert property (@(posedge clk) disable iff (rst)
        out_last |-> out_valid)
        else $error("out_last high without out_valid");

    txd_idle_low: assert property (@(posedge clk) disable iff (rst)
        (pin_txd & ~pin_send) == '0)
        else $error("pin_txd high on a channel that is not sending");

    busy_outlasts_send: assert property (@(posedge clk) disable iff (rst)
        $fell(cmd_busy) |-> (pin_send == '0))
        else $error("cmd_busy fell while a channel was still sending");

    // frame opens with the header byte
    frame_header: assert property (@(posedge clk) disable iff (rst)
        $rose(out_valid) |-> (out_data == `FRAME_HDR))
        else $error("dump frame does not start with the header byte");

    frame_contiguous: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_last) |=> out_valid)
        else $error("out_valid dropped before out_last");

endmodule

bind bench_top bench_checker checker_inst (
    .clk(clk),
    .rst(rst),
    .cmd_busy(cmd_busy),
    .pin_send(pin_send),
    .pin_txd(pin_txd),
    .out_valid(out_valid),
    .out_data(out_data),
    .out_last(out_last)
);

`default_nettype wire

//--- verif/bench_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "bench_defs.svh"

module bench_tb;

    localparam int FRAME_LEN = 1 + `N_CHAN*(`CAP_DEPTH+2);
    localparam int SEND_LEN  = 8*`CAP_DEPTH + 16;
    localparam int READ_LEN  = 8*(`CAP_DEPTH+4) + 16;
    localparam int DUMP_LEN  = FRAME_LEN + 16;
    localparam int TOTAL_CYC = 5*SEND_LEN + 2*READ_LEN + 4*DUMP_LEN + 32;

    logic               clk;
    logic               rst;
    logic               cmd_valid;
    cmd_pkg::op_e       cmd_op;
    logic [`N_CHAN-1:0] cmd_mask;
    chan_pkg::pat_e     cmd_btype;
    logic               cmd_busy;
    logic [`N_CHAN-1:0] pin_rxd;
    logic [`N_CHAN-1:0] pin_read;
    logic [`N_CHAN-1:0] pin_txd;
    logic [`N_CHAN-1:0] pin_send;
    logic               out_valid;
    logic [7:0]         out_data;
    logic               out_last;

    int         errors;
    int         err_mark;
    int         tests;
    int         tests_bad;
    logic [7:0] frame [FRAME_LEN];
    logic [7:0] exp_err [`N_CHAN];
    logic [7:0] exp_cnt [`N_CHAN];
    logic [7:0] exp_cap [`N_CHAN][`CAP_DEPTH];
    logic [7:0] rx_data [`N_CHAN][`CAP_DEPTH+4]; // link model bytes per channel
    int         rx_bits [`N_CHAN];

    bench_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (2*TOTAL_CYC) @(posedge clk);
        $display("watchdog expired after %0d cycles, run did not finish", 2*TOTAL_CYC);
        $display("STATUS: FAIL");
        $finish;
    end

    // byte k of a pattern type
    function automatic logic [7:0] pat_ref(input chan_pkg::pat_e ptype, input int k);
        logic [7:0] b;
        int         i;
        b = 8'h01;
        case (ptype)
            chan_pkg::PAT_ZERO: b = 8'h00;
            chan_pkg::PAT_ONES: b = 8'hFF;
            chan_pkg::PAT_INC:  b = 8'(k);
            default: begin
                for (i = 0; i < k; i++)
                    b = {b[6:0], b[7] ^ b[5] ^ b[4] ^ b[3]};
            end
        endcase
        return b;
    endfunction

    task automatic byte_matches(input string name, input logic [7:0] got,
                                input logic [7:0] exp);
        assert (got == exp) else begin
            $display("Fail at %0t ns: %s expected %02h got %02h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic int_matches(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("Fail at %0t ns: %s expected %0d got %0d", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic report_test(input string name);
        tests++;
        if (errors == err_mark) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            tests_bad++;
            $display("test %0d %s: %0d errors", tests, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // called on a falling edge, returns one falling edge later
    task automatic issue_cmd(input cmd_pkg::op_e op, input logic [`N_CHAN-1:0] mask,
                             input chan_pkg::pat_e t);
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_mask  = mask;
        cmd_btype = t;
        @(negedge clk);
        cmd_valid = 1'b0;
        cmd_op    = cmd_pkg::OP_NOP;
    endtask

    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        while (cmd_busy && n < limit) begin
            @(negedge clk);
            n++;
        end
        assert (!cmd_busy) else begin
            $display("Error at %0t ns: cmd_busy still high after %0d cycles", $time, limit);
            errors++;
        end
    endtask

    task automatic dump_and_check();
        int lat;
        int n;
        int last_idx;
        int base;
        int ch;
        int k;
        issue_cmd(cmd_pkg::OP_DUMP, '0, chan_pkg::PAT_ZERO);
        lat = 0;
        while (!out_valid && lat < 8) begin
            @(negedge clk);
            lat++;
        end
        assert (lat >= 2 && lat <= 3) else begin
            $display("Fail at %0t ns: frame start expected 2..3 cycles got %0d", $time, lat);
            errors++;
        end
        n = 0;
        last_idx = -1;
        while (out_valid && n < FRAME_LEN + 4) begin
            if (n < FRAME_LEN)
                frame[n] = out_data;
            if (out_last)
                last_idx = n;
            n++;
            @(negedge clk);
        end
        int_matches("frame length", n, FRAME_LEN);
        int_matches("out_last index", last_idx, FRAME_LEN - 1);
        wait_idle(8);
        byte_matches("frame header", frame[0], `FRAME_HDR);
        for (ch = 0; ch < `N_CHAN; ch++) begin
            base = 1 + ch*(`CAP_DEPTH+2);
            byte_matches($sformatf("err_cnt[%0d]", ch), frame[base], exp_err[ch]);
            byte_matches($sformatf("byte_cnt[%0d]", ch), frame[base+1], exp_cnt[ch]);
            for (k = 0; k < `CAP_DEPTH; k++)
                byte_matches($sformatf("cap_data[%0d][%0d]", ch, k), frame[base+2+k],
                             exp_cap[ch][k]);
        end
    endtask

    task automatic send_test(input chan_pkg::pat_e t);
        logic [`N_CHAN-1:0]      mask;
        logic [8*`CAP_DEPTH-1:0] tx_bits [`N_CHAN];
        int                      hi_cnt [`N_CHAN];
        int                      cyc;
        int                      ch;
        int                      k;
        mask = `N_CHAN'($urandom);
        for (ch = 0; ch < `N_CHAN; ch++) begin
            hi_cnt[ch]  = 0;
            tx_bits[ch] = '0;
        end
        issue_cmd(cmd_pkg::OP_SEND, mask, t);
        int_matches("cmd_busy", 32'(cmd_busy), 1);
        cyc = 0;
        while (cmd_busy && cyc < SEND_LEN) begin
            for (ch = 0; ch < `N_CHAN; ch++) begin
                if (pin_send[ch]) begin
                    if (hi_cnt[ch] < 8*`CAP_DEPTH)
                        tx_bits[ch][hi_cnt[ch]] = pin_txd[ch]; // lsb first on the wire
                    hi_cnt[ch]++;
                end
            end
            @(negedge clk);
            cyc++;
        end
        wait_idle(4);
        for (ch = 0; ch < `N_CHAN; ch++) begin
            if (mask[ch]) begin
                int_matches($sformatf("pin_send[%0d] cycles", ch), hi_cnt[ch], 8*`CAP_DEPTH);
                for (k = 0; k < `CAP_DEPTH; k++)
                    byte_matches($sformatf("pin_txd[%0d] byte %0d", ch, k),
                                 tx_bits[ch][8*k +: 8], pat_ref(t, k));
            end else begin
                int_matches($sformatf("pin_send[%0d] cycles", ch), hi_cnt[ch], 0);
            end
        end
    endtask

    // leaves pin_read high on the longest channels when it returns
    task automatic drive_read(input chan_pkg::pat_e t);
        int b;
        int ch;
        int max_bits;
        max_bits = 0;
        for (ch = 0; ch < `N_CHAN; ch++)
            if (rx_bits[ch] > max_bits)
                max_bits = rx_bits[ch];
        issue_cmd(cmd_pkg::OP_READ, '1, t);
        @(negedge clk); // channels arm one cycle after fs_read
        for (b = 0; b < max_bits; b++) begin
            for (ch = 0; ch < `N_CHAN; ch++) begin
                pin_read[ch] = (b < rx_bits[ch]);
                pin_rxd[ch]  = (b < rx_bits[ch]) ? rx_data[ch][b/8][b%8] : 1'b0;
            end
            @(negedge clk);
        end
    endtask

    initial begin
        chan_pkg::pat_e     t;
        logic [`N_CHAN-1:0] mask;
        logic [7:0]         d;
        int                 ch;
        int                 k;
        int                 n;
        void'($urandom(80014));
        errors    = 0;
        err_mark  = 0;
        tests     = 0;
        tests_bad = 0;
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd_op    = cmd_pkg::OP_NOP;
        cmd_mask  = '0;
        cmd_btype = chan_pkg::PAT_ZERO;
        pin_rxd   = '0;
        pin_read  = '0;
        for (ch = 0; ch < `N_CHAN; ch++) begin
            exp_err[ch] = 8'h00;
            exp_cnt[ch] = 8'h00;
            for (k = 0; k < `CAP_DEPTH; k++)
                exp_cap[ch][k] = 8'h00;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        int_matches("cmd_busy", 32'(cmd_busy), 0);
        byte_matches("pin_send", pin_send, 8'h00);
        int_matches("out_valid", 32'(out_valid), 0);
        dump_and_check();
        report_test("reset and empty dump");

        for (k = 0; k < 4; k++) begin
            send_test(chan_pkg::pat_e'(2'(k)));
            report_test($sformatf("send pattern %0d", k));
        end

        // byte 0 and the bytes past the limit are inverted
        t = chan_pkg::pat_e'(2'($urandom));
        for (ch = 0; ch < `N_CHAN; ch++) begin
            exp_cnt[ch] = 8'(`CAP_DEPTH);
            exp_err[ch] = 8'h01;
            for (k = 0; k < `CAP_DEPTH + 4; k++)
                rx_data[ch][k] = (k > 0 && k < `CAP_DEPTH) ? pat_ref(t, k) : ~pat_ref(t, k);
            for (k = 0; k < `CAP_DEPTH; k++)
                exp_cap[ch][k] = rx_data[ch][k];
            rx_bits[ch] = 8*(`CAP_DEPTH + 4);
        end
        drive_read(t);
        int_matches("cmd_busy", 32'(cmd_busy), 0); // done before pin_read drops
        pin_read = '0;
        pin_rxd  = '0;
        wait_idle(8);
        dump_and_check();
        report_test("read stopped by depth limit");

        t = chan_pkg::pat_e'(2'($urandom));
        for (ch = 0; ch < `N_CHAN; ch++) begin
            n = 1 + int'($urandom % 16);
            exp_cnt[ch] = 8'(n);
            exp_err[ch] = 8'h00;
            for (k = 0; k < `CAP_DEPTH + 4; k++) begin
                d = pat_ref(t, k);
                if (k < n && $urandom % 4 == 0) begin
                    d = d ^ 8'(1 << ($urandom % 8)); // one flipped bit
                    exp_err[ch]++;
                end
                rx_data[ch][k] = d;
                if (k < `CAP_DEPTH)
                    exp_cap[ch][k] = (k < n) ? d : 8'h00;
            end
            rx_bits[ch] = 8*n + ((n < `CAP_DEPTH) ? int'($urandom % 8) : 0);
        end
        drive_read(t);
        pin_read = '0;
        pin_rxd  = '0;
        wait_idle(8);
        dump_and_check();
        report_test("read with random lengths and errors");

        issue_cmd(cmd_pkg::OP_SEND, `N_CHAN'(1), chan_pkg::PAT_INC);
        issue_cmd(cmd_pkg::OP_CLEAR, '1, chan_pkg::PAT_ZERO); // dropped, console busy
        wait_idle(SEND_LEN);
        mask = `N_CHAN'($urandom);
        if (mask == '0)
            mask = `N_CHAN'(8'h0F);
        if (mask == '1)
            mask = `N_CHAN'(8'hF0);
        issue_cmd(cmd_pkg::OP_CLEAR, mask, chan_pkg::PAT_ZERO);
        int_matches("cmd_busy", 32'(cmd_busy), 0);
        for (ch = 0; ch < `N_CHAN; ch++) begin
            if (mask[ch]) begin
                exp_err[ch] = 8'h00;
                exp_cnt[ch] = 8'h00;
                for (k = 0; k < `CAP_DEPTH; k++)
                    exp_cap[ch][k] = 8'h00;
            end
        end
        dump_and_check();
        report_test("clear on partial mask");

        $display("tests run %0d, tests failed %0d, failed checks %0d", tests, tests_bad, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
